// File: source/stringAccel_defs.svh
// ------------------------------
// String accelerator constants
// STR_LEN must be a multiple of 4, at most 16
// Only two words per string are mapped
// ------------------------------
`ifndef STRINGACCEL_DEFS_SVH
`define STRINGACCEL_DEFS_SVH

`define STR_LEN 8 // Characters per string

// Byte offsets on the 5-bit AXI address
`define REG_A0     5'h00
`define REG_A1     5'h04
`define REG_B0     5'h08
`define REG_B1     5'h0C
`define REG_CTRL   5'h10
`define REG_STATUS 5'h14 // Read only
`define REG_RES0   5'h18 // Read only
`define REG_RES1   5'h1C // Read only

`define CTRL_START_BIT  0 // Self-clearing
`define CTRL_OP_LSB     4 // Opcode in bits 7:4

`define STATUS_DONE_BIT 0
`define STATUS_BUSY_BIT 1
`define STATUS_ERR_BIT  2

`endif

// File: source/stringAccelPkg.sv
// ------------------------------
// Shared types of the string accelerator
// String length comes from the defs header
// ------------------------------
`include "stringAccel_defs.svh"

package stringAccelPkg;

  // Engine operations, other codes are invalid
  typedef enum logic [3:0] {
    OP_COMPARE = 4'd0,
    OP_UPPER   = 4'd1,
    OP_LOWER   = 4'd2,
    OP_REVERSE = 4'd3
  } opcode_t;

  // Engine FSM states
  typedef enum logic [1:0] {
    ENG_IDLE,   // Waiting for start
    ENG_DECODE, // Opcode check
    ENG_EXEC,   // One cycle of work
    ENG_DONE    // Result registered
  } engState_t;

  // Character 0 is the low byte of word 0
  typedef logic [`STR_LEN-1:0][7:0] strBytes_t;

endpackage

// File: source/stringCmdIf.sv
// ------------------------------
// Command and result path between
// the register block and the engine
// start is a one-cycle pulse
// ------------------------------
`timescale 1ns/1ps

interface stringCmdIf;
  import stringAccelPkg::*;

  logic       start;  // Pulse from regs
  logic [3:0] op;     // Raw opcode, may be invalid
  strBytes_t  a;
  strBytes_t  b;
  strBytes_t  result; // From engine
  logic       done;
  logic       busy;
  logic       err;

  // Register block side
  modport regs (
    output start, op, a, b,
    input  result, done, busy, err
  );

  // Engine side
  modport engine (
    input  start, op, a, b,
    output result, done, busy, err
  );

endinterface

// File: source/axiLiteRegs.sv
// ------------------------------
// AXI4-Lite slave, one transaction at a time
// Byte strobes ignored, full-word writes only
// Responses always OKAY, unmapped reads give 0
// ------------------------------
`timescale 1ns/1ps
`include "stringAccel_defs.svh"

module axiLiteRegs (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [4:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  stringCmdIf.regs    cmd
);
  import stringAccelPkg::*;

  strBytes_t   aReg;
  strBytes_t   bReg;
  logic [3:0]  opReg;      // Opcode field as written
  logic        startPulse;
  logic        wrFire;     // Write handshake this cycle
  logic        rdFire;     // Read handshake this cycle
  logic [4:0]  wrOffset;
  logic [4:0]  rdOffset;
  logic [31:0] rdMux;

  // Drop a 32-bit word into string word w, bytes past STR_LEN skipped
  function automatic strBytes_t mergeWord(strBytes_t s, int w, logic [31:0] d);
    strBytes_t res;
    res = s;
    for (int i = 0; i < 4; i++) begin
      if (4 * w + i < `STR_LEN) res[4 * w + i] = d[8 * i +: 8];
    end
    return res;
  endfunction

  // Pull string word w back out, zero beyond STR_LEN
  function automatic logic [31:0] packWord(strBytes_t s, int w);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 4; i++) begin
      if (4 * w + i < `STR_LEN) word[8 * i +: 8] = s[4 * w + i];
    end
    return word;
  endfunction

  assign wrFire   = awready && awvalid && wvalid;
  assign rdFire   = arready && arvalid;
  assign wrOffset = {awaddr[4:2], 2'b00}; // Word aligned
  assign rdOffset = {araddr[4:2], 2'b00};
  assign bresp    = 2'b00; // OKAY
  assign rresp    = 2'b00;

  // Write address and data accepted together
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= 1'b0; // Single-cycle ready
      wready  <= 1'b0;
      if (awvalid && wvalid && !bvalid && !awready) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (wrFire) bvalid <= 1'b1;
      else if (bvalid && bready) bvalid <= 1'b0; // Held until bready
    end
  end

  // Operand and control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      aReg       <= '0;
      bReg       <= '0;
      opReg      <= '0;
      startPulse <= 1'b0;
    end else begin
      startPulse <= 1'b0;
      if (wrFire) begin
        case (wrOffset)
          `REG_A0: aReg <= mergeWord(aReg, 0, wdata);
          `REG_A1: aReg <= mergeWord(aReg, 1, wdata);
          `REG_B0: bReg <= mergeWord(bReg, 0, wdata);
          `REG_B1: bReg <= mergeWord(bReg, 1, wdata);
          `REG_CTRL: begin
            opReg      <= wdata[`CTRL_OP_LSB +: 4];
            startPulse <= wdata[`CTRL_START_BIT]; // Start goes out next cycle
          end
          default: ; // Read-only or unmapped
        endcase
      end
    end
  end

  // Read mux, start bit always reads 0
  always_comb begin
    rdMux = '0;
    case (rdOffset)
      `REG_A0:   rdMux = packWord(aReg, 0);
      `REG_A1:   rdMux = packWord(aReg, 1);
      `REG_B0:   rdMux = packWord(bReg, 0);
      `REG_B1:   rdMux = packWord(bReg, 1);
      `REG_CTRL: rdMux[`CTRL_OP_LSB +: 4] = opReg;
      `REG_STATUS: begin
        rdMux[`STATUS_DONE_BIT] = cmd.done;
        rdMux[`STATUS_BUSY_BIT] = cmd.busy;
        rdMux[`STATUS_ERR_BIT]  = cmd.err;
      end
      `REG_RES0: rdMux = packWord(cmd.result, 0);
      `REG_RES1: rdMux = packWord(cmd.result, 1);
      default:   rdMux = '0;
    endcase
  end

  // Read channel, data registered at the handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end else begin
      arready <= 1'b0;
      if (arvalid && !arready && !rvalid) arready <= 1'b1;
      if (rdFire) begin
        rvalid <= 1'b1;
        rdata  <= rdMux;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0; // Held until rready
      end
    end
  end

  assign cmd.start = startPulse;
  assign cmd.op    = opReg;
  assign cmd.a     = aReg;
  assign cmd.b     = bReg;

endmodule

// File: source/stringEngine.sv
// ------------------------------
// String operation FSM, one item at a time
// Result valid 3 cycles after start
// Start outside ENG_IDLE is dropped
// ------------------------------
`timescale 1ns/1ps
`include "stringAccel_defs.svh"

module stringEngine (
  input  logic       clk,
  input  logic       reset,
  stringCmdIf.engine cmd
);
  import stringAccelPkg::*;

  engState_t  state;
  logic [3:0] opCap;      // Raw opcode at start
  strBytes_t  aCap;
  strBytes_t  bCap;
  opcode_t    opSel;      // Decoded opcode
  logic       badOp;      // Set in ENG_DECODE
  strBytes_t  execResult;
  strBytes_t  resultReg;
  logic       doneReg;
  logic       errReg;

  // Next state and registered outputs
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ENG_IDLE;
      doneReg   <= 1'b0;
      errReg    <= 1'b0;
      resultReg <= '0;
      opSel     <= OP_COMPARE;
      badOp     <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (cmd.start) begin
            doneReg <= 1'b0; // Cleared by accepted start only
            state   <= ENG_DECODE;
          end
        end
        ENG_DECODE: begin
          badOp <= 1'b0;
          case (opCap)
            OP_COMPARE: opSel <= OP_COMPARE;
            OP_UPPER:   opSel <= OP_UPPER;
            OP_LOWER:   opSel <= OP_LOWER;
            OP_REVERSE: opSel <= OP_REVERSE;
            default: begin
              opSel <= OP_COMPARE;
              badOp <= 1'b1; // Flagged, run still completes
            end
          endcase
          state <= ENG_EXEC;
        end
        ENG_EXEC: begin
          resultReg <= execResult;
          errReg    <= badOp;
          doneReg   <= 1'b1;
          state     <= ENG_DONE;
        end
        ENG_DONE: state <= ENG_IDLE;
        default:  state <= ENG_IDLE;
      endcase
    end
  end

  // Operands captured with the accepted start
  always_ff @(posedge clk) begin
    if (state == ENG_IDLE && cmd.start) begin
      opCap <= cmd.op;
      aCap  <= cmd.a;
      bCap  <= cmd.b;
    end
  end

  // Single-cycle datapath
  always_comb begin
    execResult = '0;
    case (opSel)
      OP_COMPARE: execResult[0] = (aCap == bCap) ? 8'd1 : 8'd0;
      OP_UPPER: begin
        for (int i = 0; i < `STR_LEN; i++) begin
          if (aCap[i] >= "a" && aCap[i] <= "z") execResult[i] = aCap[i] - 8'd32;
          else execResult[i] = aCap[i];
        end
      end
      OP_LOWER: begin
        for (int i = 0; i < `STR_LEN; i++) begin
          if (aCap[i] >= "A" && aCap[i] <= "Z") execResult[i] = aCap[i] + 8'd32;
          else execResult[i] = aCap[i];
        end
      end
      OP_REVERSE: begin
        for (int i = 0; i < `STR_LEN; i++) begin
          execResult[i] = aCap[`STR_LEN - 1 - i]; // Mirror of A
        end
      end
      default: execResult = '0;
    endcase
    if (badOp) execResult = '0; // Invalid op gives zero result
  end

  assign cmd.busy   = (state == ENG_DECODE) || (state == ENG_EXEC);
  assign cmd.done   = doneReg;
  assign cmd.err    = errReg;
  assign cmd.result = resultReg;

endmodule

// File: source/stringAccelTop.sv
// ------------------------------
// String accelerator top level
// AXI4-Lite slave, 32-bit data, 5-bit address
// No interrupt, status is polled
// ------------------------------
`timescale 1ns/1ps

module stringAccelTop (
  input  logic        clk,
  input  logic        reset,
  // Write address and data
  input  logic [4:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  // Write response
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  // Read address
  input  logic [4:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  // Read data
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  stringCmdIf cmdIf (); // Regs to engine

  axiLiteRegs u_regs (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cmd     (cmdIf.regs)
  );

  stringEngine u_engine (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmdIf.engine)
  );

endmodule

// File: verification/stringAccelTb.sv
// ------------------------------
// Testbench for stringAccelTop over AXI4-Lite
// One transaction at a time with status polled for done
// Only words 0 and 1 of each string are mapped
// ------------------------------
`timescale 1ns/1ps
`include "stringAccel_defs.svh"

module stringAccelTb;

  typedef logic [`STR_LEN*8-1:0] strVec_t;

  localparam logic [3:0] opCompare = 4'd0;
  localparam logic [3:0] opUpper   = 4'd1;
  localparam logic [3:0] opLower   = 4'd2;
  localparam logic [3:0] opReverse = 4'd3;
  localparam int mapped = (`STR_LEN < 8) ? `STR_LEN : 8;  // Writable characters
  localparam int planTransactions = 120;                 // About 100 used plus margin
  localparam int timeoutCycles = 200 * planTransactions;

  logic        clk = 1'b0;
  logic        reset;
  logic [4:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [4:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] rngState = 32'h82aee04f;
  bit          forceHold = 1'b0;  // Long bready/rready stalls
  int          errCount = 0;
  int          testErrStart = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          cycleCount = 0;

  stringAccelTop u_stringAccelTop (.*);

  always #5 clk = ~clk;  // 10 ns period

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Timeout after %0d cycles, a DUT handshake or done never came", cycleCount);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Stall length for bready or rready
  function automatic int holdCycles();
    logic [31:0] r;
    r = nextRand();
    if (forceHold) return 2 + int'(r % 4);
    return (r[3:0] < 4'd3) ? 1 + int'(r[5:4]) : 0;  // Mostly no stall
  endfunction

  // Printable bytes with three quarters letters
  function automatic strVec_t randString();
    strVec_t     s;
    logic [31:0] r;
    s = '0;
    for (int i = 0; i < mapped; i++) begin
      r = nextRand();
      if (r[1:0] != 2'b00) s[8*i +: 8] = (r[2] ? 8'h41 : 8'h61) + 8'(r[15:8] % 26);
      else s[8*i +: 8] = 8'h20 + 8'(r[15:8] % 95);
    end
    return s;
  endfunction

  function automatic logic [31:0] wordOf(input strVec_t s, input int w);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 4; i++) begin
      if (4*w + i < `STR_LEN) word[8*i +: 8] = s[8*(4*w + i) +: 8];
    end
    return word;
  endfunction

  // Reference model of the engine
  function automatic strVec_t modelOp(input logic [3:0] op, input strVec_t a,
                                      input strVec_t b, output logic err);
    strVec_t   r;
    logic [7:0] c;
    r = '0;
    err = 1'b0;
    for (int i = 0; i < `STR_LEN; i++) begin
      c = a[8*i +: 8];
      case (op)
        opUpper:   r[8*i +: 8] = (c >= 8'h61 && c <= 8'h7a) ? c - 8'h20 : c;
        opLower:   r[8*i +: 8] = (c >= 8'h41 && c <= 8'h5a) ? c + 8'h20 : c;
        opReverse: r[8*i +: 8] = a[8*(`STR_LEN-1-i) +: 8];  // Mirror
        default:   ;
      endcase
    end
    if (op == opCompare) r[7:0] = (a == b) ? 8'd1 : 8'd0;
    else if (op > opReverse) err = 1'b1;  // Unknown opcode gives zero result
    return r;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s expected %08h actual %08h", $time, name, exp, got);
      errCount++;
    end
  endtask

  // Called and returns 1 ns after an edge
  task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data);
    int hold;
    hold = holdCycles();
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge clk); while (!(awready && wready));
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    do @(posedge clk); while (!bvalid);
    checkValue("BRESP", {30'd0, bresp}, 32'd0);
    #1 bready = 1'b0;
  endtask

  task automatic axiRead(input logic [4:0] addr, output logic [31:0] data);
    int hold;
    hold = holdCycles();
    araddr  = addr;
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    #1 arvalid = 1'b0;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;  // Stable at the handshake edge
    checkValue("RRESP", {30'd0, rresp}, 32'd0);
    #1 rready = 1'b0;
  endtask

  task automatic checkReg(input string name, input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    axiRead(addr, got);
    checkValue(name, got, exp);
  endtask

  // Poll until done while an unfinished run reports busy
  task automatic waitDone(output logic [31:0] status);
    axiRead(`REG_STATUS, status);
    while (!status[`STATUS_DONE_BIT]) begin
      checkValue("STATUS.BUSY", {31'd0, status[`STATUS_BUSY_BIT]}, 32'd1);
      axiRead(`REG_STATUS, status);
    end
  endtask

  // Load operands, start, poll, compare result and status
  task automatic runOp(input logic [3:0] op, input strVec_t a, input strVec_t b);
    strVec_t     expRes;
    logic        expErr;
    logic [31:0] status;
    logic [31:0] expStatus;
    axiWrite(`REG_A0, wordOf(a, 0));
    axiWrite(`REG_A1, wordOf(a, 1));
    axiWrite(`REG_B0, wordOf(b, 0));
    axiWrite(`REG_B1, wordOf(b, 1));
    axiWrite(`REG_CTRL, {24'd0, op, 4'd1});
    waitDone(status);
    expRes = modelOp(op, a, b, expErr);
    expStatus = '0;
    expStatus[`STATUS_DONE_BIT] = 1'b1;
    expStatus[`STATUS_ERR_BIT]  = expErr;
    checkValue("STATUS", status, expStatus);
    checkReg("RES0", `REG_RES0, wordOf(expRes, 0));
    checkReg("RES1", `REG_RES1, wordOf(expRes, 1));
  endtask

  task automatic endTest(input string name);
    if (errCount == testErrStart) begin
      passCount++;
      $display("Test %s: pass", name);
    end else begin
      failCount++;
      $display("Test %s: FAIL with %0d errors", name, errCount - testErrStart);
    end
    testErrStart = errCount;
  endtask

  initial begin
    strVec_t     a;
    strVec_t     b;
    logic [31:0] status;
    int          idx;
    reset = 1'b1;
    {awaddr, awvalid, wdata, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    checkReg("STATUS", `REG_STATUS, 32'd0);
    checkReg("RES0", `REG_RES0, 32'd0);
    checkReg("RES1", `REG_RES1, 32'd0);
    axiWrite(`REG_CTRL, {24'd0, opReverse, 4'd1});
    checkReg("CTRL", `REG_CTRL, {24'd0, opReverse, 4'd0});  // Start bit self-clears
    waitDone(status);
    endTest("reset");

    a = randString();
    runOp(opCompare, a, a);
    b = a;
    idx = int'(nextRand() % mapped);
    b[8*idx +: 8] = b[8*idx +: 8] ^ 8'(1 + nextRand() % 255);  // Never a zero flip
    runOp(opCompare, a, b);
    endTest("compare");

    a = randString();
    idx = int'(nextRand() % mapped);
    a[8*(idx % mapped) +: 8]       = 8'h40;  // '@'
    a[8*((idx + 1) % mapped) +: 8] = 8'h5b;  // '['
    a[8*((idx + 2) % mapped) +: 8] = 8'h60;  // '`'
    a[8*((idx + 3) % mapped) +: 8] = 8'h7b;  // '{'
    runOp(opUpper, a, randString());
    runOp(opLower, a, randString());
    endTest("case conversion");

    runOp(opReverse, randString(), randString());
    runOp(opReverse, randString(), randString());  // New A while idle
    endTest("reverse");

    runOp(4'd9, randString(), randString());
    runOp(opUpper, randString(), randString());  // err must drop
    endTest("invalid opcode");

    forceHold = 1'b1;
    a = randString();
    runOp(opReverse, a, randString());
    checkReg("A0", `REG_A0, wordOf(a, 0));
    checkReg("A1", `REG_A1, wordOf(a, 1));
    forceHold = 1'b0;
    endTest("back-pressure");

    $display("Summary: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: stringAccel.f
+incdir+source
source/stringAccelPkg.sv
source/stringCmdIf.sv
source/axiLiteRegs.sv
source/stringEngine.sv
source/stringAccelTop.sv
verification/stringAccelTb.sv

// File: Makefile
# Verilator simulation of the string accelerator

VERILATOR ?= verilator
TOP       ?= stringAccelTb
FLIST     ?= stringAccel.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
